/* bench/tb_pred_model.svh */
// Prediction reference model
`ifndef TB_PRED_MODEL_SVH
`define TB_PRED_MODEL_SVH

// One stimulus item, every data input of the DUT
typedef struct packed {
	logic [3:0]   mode;
	logic [3:0]   b16;
	logic [2:0]   buv;
	luma_edge_t   top_y;
	luma_edge_t   left_y;
	chroma_edge_t top_u;
	chroma_edge_t left_u;
	chroma_edge_t top_v;
	chroma_edge_t left_v;
	blk4_t        plane;
	blk4_t        orig_y;
	blk4_t        orig_c;
	pixel_t       dc_y;
	pixel_t       dc_u;
	pixel_t       dc_v;
} stim_t;

// Codes 8 and up address the chroma planes
function automatic bit is_chroma_mode(input logic [3:0] mode);
	return mode >= 4'd8;
endfunction

// Pixel k of the active reference edge, chroma k stays within 0..7
function automatic pixel_t ref_pixel(input stim_t s, input bit top, input int k);
	if (!is_chroma_mode(s.mode))
		return top ? s.top_y[k] : s.left_y[k];
	else if (s.buv[2])
		return top ? s.top_v[k] : s.left_v[k];
	else
		return top ? s.top_u[k] : s.left_u[k];
endfunction

function automatic blk4_t expect_pred(input stim_t s);
	blk4_t  p;
	int     row;
	int     col;
	pixel_t dc;
	p = '0;
	if (is_chroma_mode(s.mode)) begin
		row = int'(s.buv[1]);
		col = int'(s.buv[0]);
		dc  = s.buv[2] ? s.dc_v : s.dc_u;
	end else begin
		// Z-scan block number
		row = 2 * int'(s.b16[3]) + int'(s.b16[1]);
		col = 2 * int'(s.b16[2]) + int'(s.b16[0]);
		dc  = s.dc_y;
	end
	for (int r = 0; r < 4; r++) begin
		for (int c = 0; c < 4; c++) begin
			case (s.mode)
				MODE_Y_V, MODE_C_V:         p[r][c] = ref_pixel(s, 1'b1, 4 * col + c);
				MODE_Y_H, MODE_C_H:         p[r][c] = ref_pixel(s, 1'b0, 4 * row + r);
				MODE_Y_DC, MODE_C_DC:       p[r][c] = dc;
				MODE_Y_PLANE, MODE_C_PLANE: p[r][c] = s.plane[r][c];
				default:                    p[r][c] = '0;
			endcase
		end
	end
	return p;
endfunction

// Original minus prediction
function automatic res_blk_t expect_res(input stim_t s, input blk4_t p);
	res_blk_t res;
	blk4_t    orig;
	orig = is_chroma_mode(s.mode) ? s.orig_c : s.orig_y;
	for (int r = 0; r < 4; r++)
		for (int c = 0; c < 4; c++)
			res[r][c] = resid_t'(int'(orig[r][c]) - int'(p[r][c]));
	return res;
endfunction

`endif

/* bench/tb_intra_pe.sv */
// Intra prediction stage testbench
`timescale 1ns/10ps

module tb_intra_pe
	import pixel_pkg::*;
	import intra_mode_pkg::*;
();

	`include "tb_pred_model.svh"

	localparam int SEED           = 32'h9809_c5d9;
	localparam int MIX_LEN        = 200;
	// Luma V/H, chroma V/H, DC and plane, no prediction
	localparam int DIRECTED_ITEMS = 32 + 16 + 32 + 16;
	localparam int TEST_CYCLES    = 5 + 2 * DIRECTED_ITEMS + MIX_LEN + 1;
	localparam int TIMEOUT_NS     = (TEST_CYCLES + 50) * 10;

	logic         clk;
	logic         rst_n;
	mode_e        curr_mode;
	logic [3:0]   blk16x16_num;
	logic [2:0]   blk_uv_num;
	luma_edge_t   ref_top_y;
	luma_edge_t   ref_left_y;
	chroma_edge_t ref_top_u;
	chroma_edge_t ref_left_u;
	chroma_edge_t ref_top_v;
	chroma_edge_t ref_left_v;
	blk4_t        plane_blk;
	pixel_t       dc_y;
	pixel_t       dc_u;
	pixel_t       dc_v;
	blk4_t        orig_y;
	blk4_t        orig_c;
	blk4_t        pred_blk;
	res_blk_t     res_blk;

	intra_16x16_chroma_pe uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.curr_mode    (curr_mode),
		.blk16x16_num (blk16x16_num),
		.blk_uv_num   (blk_uv_num),
		.ref_top_y    (ref_top_y),
		.ref_left_y   (ref_left_y),
		.ref_top_u    (ref_top_u),
		.ref_left_u   (ref_left_u),
		.ref_top_v    (ref_top_v),
		.ref_left_v   (ref_left_v),
		.plane_blk    (plane_blk),
		.dc_y         (dc_y),
		.dc_u         (dc_u),
		.dc_v         (dc_v),
		.orig_y       (orig_y),
		.orig_c       (orig_c),
		.pred_blk     (pred_blk),
		.res_blk      (res_blk)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ****************************************
	// Helpers
	// ****************************************
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped on first error");
	endtask

	function automatic stim_t random_stim();
		stim_t s;
		s.mode = 4'($urandom);
		s.b16  = 4'($urandom);
		s.buv  = 3'($urandom);
		for (int i = 0; i < LUMA_EDGE; i++) begin
			s.top_y[i]  = pixel_t'($urandom);
			s.left_y[i] = pixel_t'($urandom);
		end
		for (int i = 0; i < CHROMA_EDGE; i++) begin
			s.top_u[i]  = pixel_t'($urandom);
			s.left_u[i] = pixel_t'($urandom);
			s.top_v[i]  = pixel_t'($urandom);
			s.left_v[i] = pixel_t'($urandom);
		end
		for (int r = 0; r < 4; r++) begin
			for (int c = 0; c < 4; c++) begin
				s.plane[r][c]  = pixel_t'($urandom);
				s.orig_y[r][c] = pixel_t'($urandom);
				s.orig_c[r][c] = pixel_t'($urandom);
			end
		end
		s.dc_y = pixel_t'($urandom);
		s.dc_u = pixel_t'($urandom);
		s.dc_v = pixel_t'($urandom);
		return s;
	endfunction

	// Called right after a rising edge
	task automatic apply_stim(input stim_t s);
		curr_mode    <= mode_e'(s.mode);
		blk16x16_num <= s.b16;
		blk_uv_num   <= s.buv;
		ref_top_y    <= s.top_y;
		ref_left_y   <= s.left_y;
		ref_top_u    <= s.top_u;
		ref_left_u   <= s.left_u;
		ref_top_v    <= s.top_v;
		ref_left_v   <= s.left_v;
		plane_blk    <= s.plane;
		dc_y         <= s.dc_y;
		dc_u         <= s.dc_u;
		dc_v         <= s.dc_v;
		orig_y       <= s.orig_y;
		orig_c       <= s.orig_c;
	endtask

	task automatic compare_blocks(input blk4_t exp_p, input res_blk_t exp_r, input string tag);
		assert (pred_blk === exp_p)
			else stop_on_error($sformatf("Mismatch pred_blk in %s: got %h, expected %h",
				tag, pred_blk, exp_p));
		assert (res_blk === exp_r)
			else stop_on_error($sformatf("Mismatch res_blk in %s: got %h, expected %h",
				tag, res_blk, exp_r));
	endtask

	task automatic check_outputs(input stim_t s, input string tag);
		blk4_t exp_p;
		exp_p = expect_pred(s);
		compare_blocks(exp_p, expect_res(s, exp_p), tag);
	endtask

	// One item, outputs checked one cycle later on the falling edge
	task automatic run_one(input stim_t s, input string tag);
		@(posedge clk);
		apply_stim(s);
		@(posedge clk);
		@(negedge clk);
		check_outputs(s, tag);
	endtask

	// ****************************************
	// Tests
	// ****************************************
	task automatic test_reset();
		rst_n <= 1'b0;
		apply_stim(random_stim());
		repeat (4) @(posedge clk);
		@(negedge clk);
		compare_blocks('0, '0, "reset");
		@(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic test_luma_vh();
		stim_t s;
		for (int m = 0; m < 2; m++) begin
			for (int pos = 0; pos < 16; pos++) begin
				s      = random_stim();
				s.mode = (m == 0) ? MODE_Y_V : MODE_Y_H;
				s.b16  = 4'(pos);
				run_one(s, "luma vertical/horizontal");
			end
		end
	endtask

	// Positions 0-3 are U, 4-7 are V
	task automatic test_chroma_vh();
		stim_t s;
		for (int m = 0; m < 2; m++) begin
			for (int pos = 0; pos < 8; pos++) begin
				s      = random_stim();
				s.mode = (m == 0) ? MODE_C_V : MODE_C_H;
				s.buv  = 3'(pos);
				run_one(s, "chroma vertical/horizontal");
			end
		end
	endtask

	task automatic test_dc_plane();
		logic [3:0] modes [4] = '{MODE_Y_DC, MODE_C_DC, MODE_Y_PLANE, MODE_C_PLANE};
		stim_t      s;
		for (int m = 0; m < 4; m++) begin
			for (int pos = 0; pos < 8; pos++) begin
				s      = random_stim();
				s.mode = modes[m];
				s.buv  = 3'(pos);
				run_one(s, "DC/plane");
			end
		end
	endtask

	task automatic test_no_pred();
		logic [3:0] codes [8] = '{MODE_Y_WAIT, MODE_Y_PRED, 4'd6, 4'd7,
			MODE_C_WAIT, MODE_C_PRED, 4'd14, MODE_IDLE};
		stim_t      s;
		for (int k = 0; k < 16; k++) begin
			s      = random_stim();
			s.mode = codes[k % 8];
			run_one(s, "no prediction");
		end
	endtask

	// New item every cycle, checks trail by one
	task automatic test_random_mix();
		stim_t cur;
		stim_t prev;
		for (int i = 0; i <= MIX_LEN; i++) begin
			@(posedge clk);
			if (i < MIX_LEN) begin
				cur = random_stim();
				apply_stim(cur);
			end
			@(negedge clk);
			if (i > 0)
				check_outputs(prev, "random mix");
			prev = cur;
		end
	endtask

	// ****************************************
	// Main sequence and watchdog
	// ****************************************
	initial begin
		void'($urandom(SEED));
		rst_n <= 1'b0;
		apply_stim('0);
		test_reset();
		test_luma_vh();
		test_chroma_vh();
		test_dc_plane();
		test_no_pred();
		test_random_mix();
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		stop_on_error("Timeout: the tests did not finish in the expected time");
	end

endmodule

/* common/intra_mode_pkg.sv */
// Intra mode encodings
package intra_mode_pkg;

	// Mode code from the mode decision FSM
	typedef enum logic [3:0] {
		MODE_Y_V     = 4'd0,
		MODE_Y_H     = 4'd1,
		MODE_Y_DC    = 4'd2,
		MODE_Y_PLANE = 4'd3,
		MODE_Y_WAIT  = 4'd4,
		MODE_Y_PRED  = 4'd5,
		MODE_C_DC    = 4'd8,
		MODE_C_H     = 4'd9,
		MODE_C_V     = 4'd10,
		MODE_C_PLANE = 4'd11,
		MODE_C_WAIT  = 4'd12,
		MODE_C_PRED  = 4'd13,
		MODE_IDLE    = 4'd15
	} mode_e;

	// Shape of the predicted block
	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_VERT,
		KIND_HORZ,
		KIND_DC,
		KIND_PLANE
	} pred_kind_e;

	typedef enum logic [1:0] {COMP_Y, COMP_U, COMP_V} comp_e;

endpackage

/* common/pixel_pkg.sv */
// Pixel and block types
package pixel_pkg;

	// ****************************************
	// Bit depth and edge lengths
	// ****************************************
	localparam int BIT_DEPTH   = 8;
	localparam int LUMA_EDGE   = 16;
	localparam int CHROMA_EDGE = 8;

	// ****************************************
	// Sample types
	// ****************************************
	typedef logic [BIT_DEPTH-1:0] pixel_t;

	// Original minus prediction, two's complement
	typedef logic signed [BIT_DEPTH:0] resid_t;

	// 4x4 blocks, indexed [row][col]
	typedef pixel_t [3:0][3:0] blk4_t;
	typedef resid_t [3:0][3:0] res_blk_t;

	// Reference edges, pixel 0 is the top or left end
	typedef pixel_t [LUMA_EDGE-1:0]   luma_edge_t;
	typedef pixel_t [CHROMA_EDGE-1:0] chroma_edge_t;

endpackage

/* common/pred_ctrl_if.sv */
// Prediction control bus
`timescale 1ns/10ps

interface pred_ctrl_if import intra_mode_pkg::*; ();

	// Decoded prediction kind
	pred_kind_e kind;

	// Active component for edges, DC and original
	comp_e comp;

	// Sub-block position in 4x4 units
	logic [1:0] blk_row;
	logic [1:0] blk_col;

	// Mode decoder side
	modport ctrl (
		output kind,
		output comp,
		output blk_row,
		output blk_col
	);

	// Datapath side
	modport dp (
		input kind,
		input comp,
		input blk_row,
		input blk_col
	);

endinterface

/* filelist.f */
+incdir+bench
common/pixel_pkg.sv
common/intra_mode_pkg.sv
common/pred_ctrl_if.sv
hw/intra_mode_ctrl.sv
hw/ref_edge_sel.sv
hw/pred_4x4_gen.sv
hw/residual_reg.sv
hw/intra_16x16_chroma_pe.sv
bench/tb_intra_pe.sv

/* hw/intra_16x16_chroma_pe.sv */
// Intra prediction and residual stage
`timescale 1ns/10ps

module intra_16x16_chroma_pe
	import pixel_pkg::*;
	import intra_mode_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	// Mode and block position
	input  mode_e        curr_mode,
	input  logic [3:0]   blk16x16_num,
	input  logic [2:0]   blk_uv_num,

	// Reference edges
	input  luma_edge_t   ref_top_y,
	input  luma_edge_t   ref_left_y,
	input  chroma_edge_t ref_top_u,
	input  chroma_edge_t ref_left_u,
	input  chroma_edge_t ref_top_v,
	input  chroma_edge_t ref_left_v,

	// Precomputed plane block and DC values
	input  blk4_t        plane_blk,
	input  pixel_t       dc_y,
	input  pixel_t       dc_u,
	input  pixel_t       dc_v,

	// Original pixels
	input  blk4_t        orig_y,
	input  blk4_t        orig_c,

	output blk4_t        pred_blk,
	output res_blk_t     res_blk
);

	luma_edge_t top_edge;
	luma_edge_t left_edge;
	blk4_t      pred_next;

	pred_ctrl_if ctrl_bus ();

	// ****************************************
	// Control
	// ****************************************
	intra_mode_ctrl u_mode_ctrl (
		.curr_mode    (curr_mode),
		.blk16x16_num (blk16x16_num),
		.blk_uv_num   (blk_uv_num),
		.ctrl         (ctrl_bus.ctrl)
	);

	// ****************************************
	// Datapath
	// ****************************************
	ref_edge_sel u_edge_sel (
		.ref_top_y  (ref_top_y),
		.ref_left_y (ref_left_y),
		.ref_top_u  (ref_top_u),
		.ref_left_u (ref_left_u),
		.ref_top_v  (ref_top_v),
		.ref_left_v (ref_left_v),
		.ctl        (ctrl_bus.dp),
		.top_edge   (top_edge),
		.left_edge  (left_edge)
	);

	pred_4x4_gen u_pred_gen (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctl       (ctrl_bus.dp),
		.top_edge  (top_edge),
		.left_edge (left_edge),
		.plane_blk (plane_blk),
		.dc_y      (dc_y),
		.dc_u      (dc_u),
		.dc_v      (dc_v),
		.pred_next (pred_next),
		.pred_blk  (pred_blk)
	);

	residual_reg u_residual (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctl       (ctrl_bus.dp),
		.orig_y    (orig_y),
		.orig_c    (orig_c),
		.pred_next (pred_next),
		.res_blk   (res_blk)
	);

endmodule

/* hw/intra_mode_ctrl.sv */
// Intra mode decoder
`timescale 1ns/10ps

module intra_mode_ctrl import intra_mode_pkg::*; (
	input  mode_e       curr_mode,
	input  logic [3:0]  blk16x16_num,
	input  logic [2:0]  blk_uv_num,
	pred_ctrl_if.ctrl   ctrl
);

	logic is_chroma;

	// Chroma codes all have bit 3 set, idle included
	assign is_chroma = curr_mode[3];

	// ****************************************
	// Prediction kind
	// ****************************************
	always_comb begin
		case (curr_mode)
			MODE_Y_V, MODE_C_V:         ctrl.kind = KIND_VERT;
			MODE_Y_H, MODE_C_H:         ctrl.kind = KIND_HORZ;
			MODE_Y_DC, MODE_C_DC:       ctrl.kind = KIND_DC;
			MODE_Y_PLANE, MODE_C_PLANE: ctrl.kind = KIND_PLANE;
			// Wait, pred, idle and unused codes
			default:                    ctrl.kind = KIND_NONE;
		endcase
	end

	// ****************************************
	// Component and sub-block position
	// ****************************************
	always_comb begin
		if (is_chroma) begin
			// Bit 2 picks V, low bits give a 2x2 grid
			ctrl.comp    = blk_uv_num[2] ? COMP_V : COMP_U;
			ctrl.blk_row = {1'b0, blk_uv_num[1]};
			ctrl.blk_col = {1'b0, blk_uv_num[0]};
		end else begin
			// Luma block number is in z-scan order
			ctrl.comp    = COMP_Y;
			ctrl.blk_row = {blk16x16_num[3], blk16x16_num[1]};
			ctrl.blk_col = {blk16x16_num[2], blk16x16_num[0]};
		end
	end

endmodule

/* hw/pred_4x4_gen.sv */
// 4x4 block predictor
`timescale 1ns/10ps

module pred_4x4_gen
	import pixel_pkg::*;
	import intra_mode_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	pred_ctrl_if.dp    ctl,
	input  luma_edge_t top_edge,
	input  luma_edge_t left_edge,
	input  blk4_t      plane_blk,
	input  pixel_t     dc_y,
	input  pixel_t     dc_u,
	input  pixel_t     dc_v,
	output blk4_t      pred_next,
	output blk4_t      pred_blk
);

	pixel_t dc_val;

	// DC of the active component
	always_comb begin
		case (ctl.comp)
			COMP_U:  dc_val = dc_u;
			COMP_V:  dc_val = dc_v;
			default: dc_val = dc_y;
		endcase
	end

	// ****************************************
	// Block prediction
	// ****************************************
	always_comb begin
		pred_next = '0;
		case (ctl.kind)
			KIND_VERT: begin
				for (int r = 0; r < 4; r++)
					for (int c = 0; c < 4; c++)
						pred_next[r][c] = top_edge[{ctl.blk_col, 2'(c)}];
			end
			KIND_HORZ: begin
				for (int r = 0; r < 4; r++)
					for (int c = 0; c < 4; c++)
						pred_next[r][c] = left_edge[{ctl.blk_row, 2'(r)}];
			end
			KIND_DC: begin
				for (int r = 0; r < 4; r++)
					for (int c = 0; c < 4; c++)
						pred_next[r][c] = dc_val;
			end
			// Plane samples are computed upstream
			KIND_PLANE: pred_next = plane_blk;
			default:    pred_next = '0;
		endcase
	end

	// Output register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pred_blk <= '0;
		else
			pred_blk <= pred_next;
	end

	// Edge pixel addressing needs a known sub-block position
	a_pos_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		(ctl.kind == KIND_VERT || ctl.kind == KIND_HORZ)
			|-> !$isunknown({ctl.blk_row, ctl.blk_col})
	) else $error("sub-block position is unknown for an edge prediction");

endmodule

/* hw/ref_edge_sel.sv */
// Reference edge selection
`timescale 1ns/10ps

module ref_edge_sel
	import pixel_pkg::*;
	import intra_mode_pkg::*;
(
	input  luma_edge_t   ref_top_y,
	input  luma_edge_t   ref_left_y,
	input  chroma_edge_t ref_top_u,
	input  chroma_edge_t ref_left_u,
	input  chroma_edge_t ref_top_v,
	input  chroma_edge_t ref_left_v,
	pred_ctrl_if.dp      ctl,
	output luma_edge_t   top_edge,
	output luma_edge_t   left_edge
);

	chroma_edge_t c_top;
	chroma_edge_t c_left;

	// Chroma component pick
	always_comb begin
		if (ctl.comp == COMP_V) begin
			c_top  = ref_top_v;
			c_left = ref_left_v;
		end else begin
			c_top  = ref_top_u;
			c_left = ref_left_u;
		end
	end

	// ****************************************
	// Edge expansion
	// ****************************************
	always_comb begin
		if (ctl.comp == COMP_Y) begin
			top_edge  = ref_top_y;
			left_edge = ref_left_y;
		end else begin
			// 8 chroma pixels repeat to 16, so position 1 lands on pixels 4-7
			for (int i = 0; i < LUMA_EDGE; i++) begin
				top_edge[i]  = c_top[i % CHROMA_EDGE];
				left_edge[i] = c_left[i % CHROMA_EDGE];
			end
		end
	end

endmodule

/* hw/residual_reg.sv */
// Residual subtract and register
`timescale 1ns/10ps

module residual_reg
	import pixel_pkg::*;
	import intra_mode_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	pred_ctrl_if.dp  ctl,
	input  blk4_t    orig_y,
	input  blk4_t    orig_c,
	input  blk4_t    pred_next,
	output res_blk_t res_blk
);

	blk4_t    orig_sel;
	res_blk_t res_next;

	// Chroma original is shared by U and V
	assign orig_sel = (ctl.comp == COMP_Y) ? orig_y : orig_c;

	// ****************************************
	// Per-pixel difference
	// ****************************************
	always_comb begin
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				res_next[r][c] = {1'b0, orig_sel[r][c]} - {1'b0, pred_next[r][c]};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			res_blk <= '0;
		else
			res_blk <= res_next;
	end

	// Undriven original or prediction pixels show up here
	a_res_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(res_next)
	) else $error("residual input has unknown bits");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the intra prediction testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert \
	--top-module tb_intra_pe \
	-f filelist.f \
	-o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi
